//--- flist.f
+incdir+bench
common/wb_bus_pkg.sv
common/wb_map_pkg.sv
hdl/wb_client_arbiter.sv
wb_host/wb_host_ctrl.sv
wb_host/wb_reg_bank.sv
hdl/wb_subsys_top.sv
bench/tb_wb_subsys.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_wb_subsys
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

SRCS := $(shell grep -v '^+' $(FLIST)) bench/tb_wb_model.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/tb_wb_model.svh
// Register bank reference model, LFSR source and client driver tasks for the subsystem testbench
`ifndef TB_WB_MODEL_SVH
`define TB_WB_MODEL_SVH

wb_bus_pkg::dat_t model_mem [wb_map_pkg::num_words];
logic [31:0]      lfsr_q = 32'd88513;
int               serve_order [$];

// Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int k = 0; k < n; k++) begin
        fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        val    = {val[30:0], fb};
    end
    return val;
endfunction

task automatic model_reset();
    for (int j = 0; j < wb_map_pkg::num_words; j++) begin
        model_mem[j] = wb_map_pkg::reset_seed + wb_bus_pkg::dat_t'(j) * wb_map_pkg::reset_step;
    end
endtask

// Window holds num_words words above the base, word aligned only
function automatic logic is_mapped(input wb_bus_pkg::adr_t adr);
    return (adr[31:5] == wb_map_pkg::base_default[31:5]) && (adr[1:0] == 2'b00);
endfunction

function automatic wb_bus_pkg::adr_t word_adr(input int idx);
    return wb_map_pkg::base_default + 32'(idx * 4);
endfunction

task automatic drive_client(input bit cl, input logic req, input logic we,
                            input wb_bus_pkg::adr_t adr, input wb_bus_pkg::dat_t wdat);
    if (cl == 1'b0) begin
        c0_req_i  <= req;
        c0_we_i   <= we;
        c0_adr_i  <= adr;
        c0_wdat_i <= wdat;
    end else begin
        c1_req_i  <= req;
        c1_we_i   <= we;
        c1_adr_i  <= adr;
        c1_wdat_i <= wdat;
    end
endtask

task automatic drop_req(input bit cl);
    if (cl == 1'b0) begin
        c0_req_i <= 1'b0;
    end else begin
        c1_req_i <= 1'b0;
    end
endtask

// Full four-phase exchange on one client, response sampled on rising edges
task automatic client_access(input bit cl, input logic we, input wb_bus_pkg::adr_t adr,
                             input wb_bus_pkg::dat_t wdat, input int hold, input bit chk_other,
                             output wb_bus_pkg::dat_t rdat, output logic got_err);
    logic ack_s;
    logic err_s;
    logic got_resp;
    int   cnt;
    got_resp = 1'b0;
    got_err  = 1'b0;
    ack_s    = 1'b0;
    err_s    = 1'b0;
    @(posedge clk);
    drive_client(cl, 1'b1, we, adr, wdat);
    cnt = 0;
    while (!got_resp && cnt < resp_limit) begin
        @(posedge clk);
        ack_s = cl ? c1_ack_o : c0_ack_o;
        err_s = cl ? c1_err_o : c0_err_o;
        rdat  = cl ? c1_rdat_o : c0_rdat_o;
        if (chk_other) begin
            check_other_quiet(cl);
        end
        got_resp = ack_s || err_s;
        cnt++;
    end
    if (!got_resp) begin
        report_fail($sformatf("client %0d got no ack or err within %0d cycles", cl, resp_limit));
    end else begin
        serve_order.push_back(int'(cl));
        got_err = err_s;
        if (ack_s && err_s) begin
            report_fail($sformatf("client %0d saw ack and err together", cl));
        end
        if (ack_s && we && is_mapped(adr)) begin
            model_mem[adr[4:2]] = wdat;
        end
    end
    // Response must be held while req stays high
    repeat (hold) begin
        @(posedge clk);
        if (chk_other) begin
            check_other_quiet(cl);
        end
        if (got_resp && !(cl ? (c1_ack_o || c1_err_o) : (c0_ack_o || c0_err_o))) begin
            report_fail($sformatf("client %0d response dropped while req high", cl));
        end
    end
    drop_req(cl);
    cnt = 0;
    do begin
        @(posedge clk);
        if (chk_other) begin
            check_other_quiet(cl);
        end
        cnt++;
    end while ((cl ? (c1_ack_o || c1_err_o) : (c0_ack_o || c0_err_o)) && cnt < 4);
    if (cl ? (c1_ack_o || c1_err_o) : (c0_ack_o || c0_err_o)) begin
        report_fail($sformatf("client %0d response stayed high after req dropped", cl));
    end
endtask

`endif

//--- bench/tb_wb_subsys.sv
// Testbench for the Wishbone host subsystem with random traffic checked against a bank model
module tb_wb_subsys;

    localparam int timeout_cycles = wb_bus_pkg::timeout_default;
    localparam int resp_limit     = 2 * timeout_cycles + 20;
    // Transactions issued by all tests together
    localparam int num_trans      = 86;

    logic             clk = 1'b0;
    logic             rst;
    logic             c0_req_i;
    logic             c0_we_i;
    wb_bus_pkg::adr_t c0_adr_i;
    wb_bus_pkg::dat_t c0_wdat_i;
    wb_bus_pkg::dat_t c0_rdat_o;
    logic             c0_ack_o;
    logic             c0_err_o;
    logic             c1_req_i;
    logic             c1_we_i;
    wb_bus_pkg::adr_t c1_adr_i;
    wb_bus_pkg::dat_t c1_wdat_i;
    wb_bus_pkg::dat_t c1_rdat_o;
    logic             c1_ack_o;
    logic             c1_err_o;

    int errors = 0;
    int checks = 0;

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            $display("[ERROR] %s expected %h got %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic report_fail(input string msg);
        checks++;
        $display("Failure: %s", msg);
        errors++;
    endtask

    task automatic check_other_quiet(input bit cl);
        if (cl ? (c0_ack_o || c0_err_o) : (c1_ack_o || c1_err_o)) begin
            report_fail($sformatf("client %0d responded while idle", !cl));
        end
    endtask

    `include "tb_wb_model.svh"

    wb_subsys_top u_wb_subsys_top (.*);

    always #10 clk = ~clk;

    // Watchdog sized from the worst case of every transaction
    initial begin
        repeat (num_trans * (2 * timeout_cycles + 20)) @(posedge clk);
        $display("Watchdog expired before the tests finished");
        $display("Checks failed");
        $finish;
    end

    task automatic read_all(input string tag);
        wb_bus_pkg::dat_t rd;
        logic             er;
        for (int j = 0; j < wb_map_pkg::num_words; j++) begin
            client_access(1'b0, 1'b0, word_adr(j), '0, 0, 1'b1, rd, er);
            check_value("c0_err_o", 32'd0, 32'(er));
            check_value($sformatf("c0_rdat_o word %0d %s", j, tag), model_mem[j], rd);
        end
    endtask

    initial begin
        wb_bus_pkg::dat_t rd;
        wb_bus_pkg::dat_t rd1;
        logic             er;
        logic             er1;
        logic             cl;
        logic             we;
        int               idx;
        int               e0;
        int               last_cl;
        rst = 1'b1;
        c0_req_i = 1'b0;
        c0_we_i = 1'b0;
        c0_adr_i = '0;
        c0_wdat_i = '0;
        c1_req_i = 1'b0;
        c1_we_i = 1'b0;
        c1_adr_i = '0;
        c1_wdat_i = '0;
        model_reset();
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        e0 = errors;
        read_all("after reset");
        $display("Test reset_values finished, errors %0d", errors - e0);

        e0 = errors;
        for (int n = 0; n < 60; n++) begin
            cl  = 1'(rand_bits(1));
            we  = 1'(rand_bits(1));
            idx = int'(rand_bits(3));
            client_access(cl, we, word_adr(idx), rand_bits(32), 0, 1'b1, rd, er);
            check_value(cl ? "c1_err_o" : "c0_err_o", 32'd0, 32'(er));
            if (!we) begin
                check_value(cl ? "c1_rdat_o" : "c0_rdat_o", model_mem[idx], rd);
            end
        end
        $display("Test random_write_read finished, errors %0d", errors - e0);

        e0 = errors;
        cl = 1'(rand_bits(1));
        client_access(cl, 1'b1, wb_map_pkg::base_default + 32'h100, rand_bits(32),
                      0, 1'b1, rd, er);
        check_value(cl ? "c1_err_o outside window" : "c0_err_o outside window",
                    32'd1, 32'(er));
        cl = 1'(rand_bits(1));
        client_access(cl, 1'b1, wb_map_pkg::base_default + 32'h2, rand_bits(32),
                      0, 1'b1, rd, er);
        check_value(cl ? "c1_err_o unaligned" : "c0_err_o unaligned", 32'd1, 32'(er));
        read_all("after unmapped");
        $display("Test unmapped_access finished, errors %0d", errors - e0);

        e0 = errors;
        // The client served just before the rounds also counts for the first pick
        last_cl = serve_order[$];
        serve_order.delete();
        serve_order.push_back(last_cl);
        for (int r = 0; r < 2; r++) begin
            fork
                client_access(1'b0, 1'b0, word_adr(2 * r), '0, 0, 1'b0, rd, er);
                client_access(1'b1, 1'b0, word_adr(2 * r + 5), '0, 0, 1'b0, rd1, er1);
            join
            check_value("c0_rdat_o", model_mem[2 * r], rd);
            check_value("c1_rdat_o", model_mem[2 * r + 5], rd1);
        end
        if (serve_order.size() != 5) begin
            report_fail("contention rounds did not complete four transactions");
        end else if (serve_order[0] == serve_order[1] || serve_order[1] == serve_order[2] ||
                     serve_order[2] == serve_order[3] || serve_order[3] == serve_order[4]) begin
            report_fail("a client was served twice in a row while the other waited");
        end
        $display("Test contention finished, errors %0d", errors - e0);

        e0 = errors;
        for (int n = 0; n < 4; n++) begin
            cl  = 1'(rand_bits(1));
            idx = int'(rand_bits(3));
            client_access(cl, 1'b0, word_adr(idx), '0, int'(rand_bits(3)), 1'b1, rd, er);
            check_value(cl ? "c1_rdat_o" : "c0_rdat_o", model_mem[idx], rd);
        end
        $display("Test four_phase finished, errors %0d", errors - e0);

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- hdl/wb_subsys_top.sv
// Wishbone host subsystem top joining client arbiter, host controller and register bank
module wb_subsys_top #(
    parameter int               TIMEOUT_CYCLES = wb_bus_pkg::timeout_default,
    parameter wb_bus_pkg::adr_t BASE_ADDR      = wb_map_pkg::base_default
) (
    input  logic             clk,
    input  logic             rst,

    input  logic             c0_req_i,
    input  logic             c0_we_i,
    input  wb_bus_pkg::adr_t c0_adr_i,
    input  wb_bus_pkg::dat_t c0_wdat_i,
    output wb_bus_pkg::dat_t c0_rdat_o,
    output logic             c0_ack_o,
    output logic             c0_err_o,

    input  logic             c1_req_i,
    input  logic             c1_we_i,
    input  wb_bus_pkg::adr_t c1_adr_i,
    input  wb_bus_pkg::dat_t c1_wdat_i,
    output wb_bus_pkg::dat_t c1_rdat_o,
    output logic             c1_ack_o,
    output logic             c1_err_o
);

    // Arbiter to host
    logic             m_cyc;
    logic             m_stb;
    logic             m_we;
    wb_bus_pkg::adr_t m_adr;
    wb_bus_pkg::dat_t m_wdat;
    wb_bus_pkg::dat_t m_rdat;
    logic             m_ack;
    logic             m_err;

    // Host to register bank
    logic             s_stb;
    logic             s_we;
    wb_bus_pkg::adr_t s_adr;
    wb_bus_pkg::dat_t s_wdat;
    wb_bus_pkg::dat_t s_rdat;
    logic             s_ack;

    wb_client_arbiter u_arbiter (
        .clk       (clk),
        .rst       (rst),
        .c0_req_i  (c0_req_i),
        .c0_we_i   (c0_we_i),
        .c0_adr_i  (c0_adr_i),
        .c0_wdat_i (c0_wdat_i),
        .c0_rdat_o (c0_rdat_o),
        .c0_ack_o  (c0_ack_o),
        .c0_err_o  (c0_err_o),
        .c1_req_i  (c1_req_i),
        .c1_we_i   (c1_we_i),
        .c1_adr_i  (c1_adr_i),
        .c1_wdat_i (c1_wdat_i),
        .c1_rdat_o (c1_rdat_o),
        .c1_ack_o  (c1_ack_o),
        .c1_err_o  (c1_err_o),
        .m_cyc_o   (m_cyc),
        .m_stb_o   (m_stb),
        .m_we_o    (m_we),
        .m_adr_o   (m_adr),
        .m_wdat_o  (m_wdat),
        .m_rdat_i  (m_rdat),
        .m_ack_i   (m_ack),
        .m_err_i   (m_err)
    );

    wb_host_ctrl #(
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
    ) u_host (
        .clk      (clk),
        .rst      (rst),
        .cyc_i    (m_cyc),
        .stb_i    (m_stb),
        .we_i     (m_we),
        .adr_i    (m_adr),
        .wdat_i   (m_wdat),
        .rdat_o   (m_rdat),
        .ack_o    (m_ack),
        .err_o    (m_err),
        .s_stb_o  (s_stb),
        .s_we_o   (s_we),
        .s_adr_o  (s_adr),
        .s_wdat_o (s_wdat),
        .s_rdat_i (s_rdat),
        .s_ack_i  (s_ack)
    );

    wb_reg_bank #(
        .BASE_ADDR (BASE_ADDR)
    ) u_bank (
        .clk      (clk),
        .rst      (rst),
        .s_stb_i  (s_stb),
        .s_we_i   (s_we),
        .s_adr_i  (s_adr),
        .s_wdat_i (s_wdat),
        .s_rdat_o (s_rdat),
        .s_ack_o  (s_ack)
    );

endmodule

//--- wb_host/wb_reg_bank.sv
// Eight-word register slave with window decode and indexed reset values
module wb_reg_bank #(
    parameter wb_bus_pkg::adr_t BASE_ADDR = wb_map_pkg::base_default
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             s_stb_i,
    input  logic             s_we_i,
    input  wb_bus_pkg::adr_t s_adr_i,
    input  wb_bus_pkg::dat_t s_wdat_i,
    output wb_bus_pkg::dat_t s_rdat_o,
    output logic             s_ack_o
);

    localparam int IDX_W   = $bits(wb_map_pkg::idx_t);
    // First address bit above the word index
    localparam int WIN_LSB = IDX_W + 2;

    wb_bus_pkg::dat_t  regs [wb_map_pkg::num_words];
    wb_map_pkg::idx_t  idx;
    logic              hit;
    logic              do_wr;

    assign idx = s_adr_i[WIN_LSB-1:2];

    // Inside the window and word aligned
    assign hit = (s_adr_i[wb_bus_pkg::adr_w-1:WIN_LSB] ==
                  BASE_ADDR[wb_bus_pkg::adr_w-1:WIN_LSB]) &&
                 (s_adr_i[1:0] == 2'b00);

    assign do_wr = s_stb_i && hit && s_we_i;

    // Each word comes out of reset at its indexed value
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int j = 0; j < wb_map_pkg::num_words; j++) begin
                regs[j] <= wb_map_pkg::reset_word(j);
            end
        end else if (do_wr) begin
            regs[idx] <= s_wdat_i;
        end
    end

    // Unmapped strobes get no ack, host times them out
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s_ack_o <= 1'b0;
        end else begin
            s_ack_o <= s_stb_i && hit;
        end
    end

    always_ff @(posedge clk) begin
        if (s_stb_i && hit && !s_we_i) begin
            s_rdat_o <= regs[idx];
        end
    end

    // A held strobe would write and ack twice
    a_stb_single : assert property (
        @(posedge clk) disable iff (rst) s_stb_i |=> !s_stb_i
    );

endmodule

//--- wb_host/wb_host_ctrl.sv
// Wishbone host controller, forwards a cycle to the slave and ends it with ack or timeout err
module wb_host_ctrl #(
    parameter int TIMEOUT_CYCLES = wb_bus_pkg::timeout_default
) (
    input  logic             clk,
    input  logic             rst,

    // From the arbiter
    input  logic             cyc_i,
    input  logic             stb_i,
    input  logic             we_i,
    input  wb_bus_pkg::adr_t adr_i,
    input  wb_bus_pkg::dat_t wdat_i,
    output wb_bus_pkg::dat_t rdat_o,
    output logic             ack_o,
    output logic             err_o,

    // To the slave
    output logic             s_stb_o,
    output logic             s_we_o,
    output wb_bus_pkg::adr_t s_adr_o,
    output wb_bus_pkg::dat_t s_wdat_o,
    input  wb_bus_pkg::dat_t s_rdat_i,
    input  logic             s_ack_i
);

    localparam int CNT_W = $clog2(TIMEOUT_CYCLES);

    wb_bus_pkg::host_state_e state;
    logic [CNT_W-1:0]        tmo_cnt;
    logic                    timeout_hit;

    // Counts only while a cycle waits in st_access
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tmo_cnt <= '0;
        end else if (cyc_i && stb_i && state == wb_bus_pkg::st_access) begin
            tmo_cnt <= tmo_cnt + 1'b1;
        end else begin
            tmo_cnt <= '0;
        end
    end

    assign timeout_hit = (state == wb_bus_pkg::st_access) && !s_ack_i &&
                         (tmo_cnt == CNT_W'(TIMEOUT_CYCLES - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= wb_bus_pkg::st_idle;
            ack_o   <= 1'b0;
            err_o   <= 1'b0;
            s_stb_o <= 1'b0;
        end else begin
            s_stb_o <= 1'b0;
            case (state)
                wb_bus_pkg::st_idle: begin
                    ack_o <= 1'b0;
                    err_o <= 1'b0;
                    if (cyc_i && stb_i) begin
                        s_stb_o <= 1'b1;
                        state   <= wb_bus_pkg::st_access;
                    end
                end
                wb_bus_pkg::st_access: begin
                    if (s_ack_i) begin
                        ack_o <= 1'b1;
                        state <= wb_bus_pkg::st_complete;
                    end
                end
                wb_bus_pkg::st_complete: begin
                    ack_o <= 1'b0;
                    err_o <= 1'b0;
                    state <= wb_bus_pkg::st_idle;
                end
                default: state <= wb_bus_pkg::st_idle;
            endcase

            // Timeout wins over the normal flow
            if (timeout_hit) begin
                err_o <= 1'b1;
                ack_o <= 1'b0;
                state <= wb_bus_pkg::st_complete;
            end
        end
    end

    // Slave request captured as the cycle starts, read data on ack
    always_ff @(posedge clk) begin
        if (state == wb_bus_pkg::st_idle && cyc_i && stb_i) begin
            s_we_o   <= we_i;
            s_adr_o  <= adr_i;
            s_wdat_o <= wdat_i;
        end
        if (state == wb_bus_pkg::st_access && s_ack_i) begin
            rdat_o <= s_rdat_i;
        end
    end

    // A slave ack outside st_access would be lost
    a_ack_in_access : assert property (
        @(posedge clk) disable iff (rst) s_ack_i |-> state == wb_bus_pkg::st_access
    );

    // Master keeps the cycle up until the host answers
    a_cyc_held : assert property (
        @(posedge clk) disable iff (rst)
        state == wb_bus_pkg::st_access |-> cyc_i && stb_i
    );

endmodule

//--- hdl/wb_client_arbiter.sv
// Round-robin arbiter from two four-phase client handshakes onto one Wishbone master
module wb_client_arbiter (
    input  logic             clk,
    input  logic             rst,

    // Client 0
    input  logic             c0_req_i,
    input  logic             c0_we_i,
    input  wb_bus_pkg::adr_t c0_adr_i,
    input  wb_bus_pkg::dat_t c0_wdat_i,
    output wb_bus_pkg::dat_t c0_rdat_o,
    output logic             c0_ack_o,
    output logic             c0_err_o,

    // Client 1
    input  logic             c1_req_i,
    input  logic             c1_we_i,
    input  wb_bus_pkg::adr_t c1_adr_i,
    input  wb_bus_pkg::dat_t c1_wdat_i,
    output wb_bus_pkg::dat_t c1_rdat_o,
    output logic             c1_ack_o,
    output logic             c1_err_o,

    // Wishbone master side
    output logic             m_cyc_o,
    output logic             m_stb_o,
    output logic             m_we_o,
    output wb_bus_pkg::adr_t m_adr_o,
    output wb_bus_pkg::dat_t m_wdat_o,
    input  wb_bus_pkg::dat_t m_rdat_i,
    input  logic             m_ack_i,
    input  logic             m_err_i
);

    // Granted client, 0 or 1
    logic             gnt_q;
    // Client served by the last finished cycle
    logic             last_q;
    // Bus cycle in progress
    logic             cyc_q;
    // Response held towards the granted client
    logic             hold_q;
    logic             err_q;
    wb_bus_pkg::dat_t rdat_q;

    logic             pick;
    logic             gnt_req;

    // Both asking means the one not served last wins
    always_comb begin
        if (c0_req_i && c1_req_i) begin
            pick = ~last_q;
        end else begin
            pick = c1_req_i;
        end
    end

    assign gnt_req = gnt_q ? c1_req_i : c0_req_i;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            gnt_q  <= 1'b0;
            last_q <= 1'b1;
            cyc_q  <= 1'b0;
            hold_q <= 1'b0;
            err_q  <= 1'b0;
        end else if (!cyc_q && !hold_q) begin
            // Free bus, start a cycle for any requester
            if (c0_req_i || c1_req_i) begin
                gnt_q <= pick;
                cyc_q <= 1'b1;
            end
        end else if (cyc_q) begin
            if (m_ack_i || m_err_i) begin
                cyc_q  <= 1'b0;
                hold_q <= 1'b1;
                err_q  <= m_err_i;
                last_q <= gnt_q;
            end
        end else if (!gnt_req) begin
            // Client dropped req, end of the four-phase exchange
            hold_q <= 1'b0;
        end
    end

    // Read data captured with the bus response
    always_ff @(posedge clk) begin
        if (cyc_q && (m_ack_i || m_err_i)) begin
            rdat_q <= m_rdat_i;
        end
    end

    assign m_cyc_o  = cyc_q;
    assign m_stb_o  = cyc_q;
    assign m_we_o   = gnt_q ? c1_we_i : c0_we_i;
    assign m_adr_o  = gnt_q ? c1_adr_i : c0_adr_i;
    assign m_wdat_o = gnt_q ? c1_wdat_i : c0_wdat_i;

    assign c0_rdat_o = rdat_q;
    assign c1_rdat_o = rdat_q;

    assign c0_ack_o = hold_q && !err_q && !gnt_q;
    assign c0_err_o = hold_q && err_q && !gnt_q;
    assign c1_ack_o = hold_q && !err_q && gnt_q;
    assign c1_err_o = hold_q && err_q && gnt_q;

    // Host answers only inside a cycle, and never with ack and err together
    a_resp_in_cycle : assert property (
        @(posedge clk) disable iff (rst)
        (m_ack_i || m_err_i) |-> m_cyc_o && !(m_ack_i && m_err_i)
    );

endmodule

//--- common/wb_map_pkg.sv
// Register bank address map package with word count and reset value rule
package wb_map_pkg;

    // Number of registers in the bank
    localparam int num_words = 8;

    typedef logic [$clog2(num_words)-1:0] idx_t;

    // Default base of the bank window, byte addressed
    localparam logic [31:0] base_default = 32'h0000_1000;

    // Word 0 resets to the seed, each further word adds one step
    localparam logic [31:0] reset_seed = 32'h9ABC_DEF0;
    localparam logic [31:0] reset_step = 32'h0000_0200;

    // Reset value of word j
    function automatic wb_bus_pkg::dat_t reset_word(input int unsigned j);
        wb_bus_pkg::dat_t step_sum;
        step_sum = wb_bus_pkg::dat_t'(j) * reset_step;
        return reset_seed + step_sum;
    endfunction

endpackage

//--- common/wb_bus_pkg.sv
// Wishbone bus package with widths, host state encoding and timing constants
package wb_bus_pkg;

    // Bus widths
    localparam int adr_w = 32;
    localparam int dat_w = 32;

    typedef logic [adr_w-1:0] adr_t;
    typedef logic [dat_w-1:0] dat_t;

    // Host controller states
    // A cycle enters st_access on cyc and stb, and leaves through st_complete
    typedef enum logic [1:0] {
        st_idle     = 2'b00,
        st_access   = 2'b01,
        st_complete = 2'b10
    } host_state_e;

    // Cycles the host waits for a slave ack before it answers with err
    localparam int timeout_default = 16;

endpackage
